// File: Bender.yml
package:
  name: fifo_axi_wr_dma

export_include_dirs:
  - .

sources:
  - dma_pkg.sv
  - wr_burst_fsm.sv
  - wr_beat_counter.sv
  - wr_addr_ring.sv
  - fifo_axi_wr_dma.sv
  - target: test
    files:
      - dma_checker.sv
      - tb_fifo_axi_wr_dma.sv

// File: dma_cfg.svh
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

`default_nettype none

// beat address, one step per beat
`define DMA_ADDR_W 32

`define DMA_DATA_W 32

// axi awlen, beats minus one
`define DMA_LEN_W 8

`define DMA_CLK_PERIOD 40

`default_nettype wire

`endif

// File: dma_checker.sv
`timescale 1ns/1ns
`default_nettype none

module dma_checker (
    input logic           clk,
    input logic           dma_rstn_sync,
    input logic           awvalid_i,
    input logic           awready_i,
    input dma_pkg::addr_t awaddr_i,
    input dma_pkg::len_t  awlen_i,
    input logic           wvalid_i,
    input logic           wlast_i,
    input logic           bready_i
);
    int fail_cnt = 0;  // read by the testbench

    aw_hold: assert property (@(posedge clk) disable iff (!dma_rstn_sync)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awlen_i))
        else begin
            $error("AW valid, address or length changed before AWREADY");
            fail_cnt = fail_cnt + 1;
        end

    wlast_needs_wvalid: assert property (@(posedge clk) disable iff (!dma_rstn_sync)
        wlast_i |-> wvalid_i)
        else begin
            $error("WLAST high without WVALID");
            fail_cnt = fail_cnt + 1;
        end

    // one burst in flight, so no new address while waiting for B
    b_aw_exclusive: assert property (@(posedge clk) disable iff (!dma_rstn_sync)
        !(bready_i && awvalid_i))
        else begin
            $error("BREADY and AWVALID high together");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind fifo_axi_wr_dma dma_checker i_checker (
    .clk           (clk),
    .dma_rstn_sync (dma_rstn_sync),
    .awvalid_i     (m_awvalid_o),
    .awready_i     (m_awready_i),
    .awaddr_i      (m_awaddr_o),
    .awlen_i       (m_awlen_o),
    .wvalid_i      (m_wvalid_o),
    .wlast_i       (m_wlast_o),
    .bready_i      (m_bready_o)
);

`default_nettype wire

// File: dma_pkg.sv
`include "dma_cfg.svh"
`default_nettype none

package dma_pkg;

    typedef logic [`DMA_ADDR_W-1:0] addr_t;
    typedef logic [`DMA_DATA_W-1:0] data_t;
    typedef logic [`DMA_LEN_W-1:0]  len_t;   // beats minus one

    // one-hot, *_SPLIT states carry the first half of a wrapped burst
    typedef enum logic [8:0] {
        ST_FIRST_LOAD = 9'b0_0000_0001,
        ST_IDLE       = 9'b0_0000_0010,
        ST_LOAD_BURST = 9'b0_0000_0100,
        ST_ADDR       = 9'b0_0000_1000,
        ST_DATA       = 9'b0_0001_0000,
        ST_RESP       = 9'b0_0010_0000,
        ST_ADDR_SPLIT = 9'b0_0100_0000,
        ST_DATA_SPLIT = 9'b0_1000_0000,
        ST_RESP_SPLIT = 9'b1_0000_0000
    } burst_state_t;

endpackage

`default_nettype wire

// File: fifo_axi_wr_dma.sv
`timescale 1ns/1ns
`default_nettype none

module fifo_axi_wr_dma (
    input  logic           clk,
    input  logic           dma_rstn_sync,
    input  dma_pkg::addr_t start_addr_i,
    input  dma_pkg::addr_t end_addr_i,
    input  logic           capture_en_i,
    input  logic           addr_reset_i,
    input  logic           burst_valid_i,
    output logic           burst_ready_o,
    input  dma_pkg::len_t  burst_len_i,
    input  logic           fifo_valid_i,
    output logic           fifo_ready_o,
    input  dma_pkg::data_t fifo_data_i,
    output dma_pkg::addr_t m_awaddr_o,
    output dma_pkg::len_t  m_awlen_o,
    output logic           m_awvalid_o,
    input  logic           m_awready_i,
    output dma_pkg::data_t m_wdata_o,
    output logic           m_wlast_o,
    output logic           m_wvalid_o,
    input  logic           m_wready_i,
    input  logic           m_bvalid_i,
    output logic           m_bready_o
);
    logic need_split;
    logic last_beat;
    logic load_start;
    logic accept;
    logic split_next;
    logic advance;
    logic aw_fire;
    logic w_fire;
    logic in_data;

    wr_burst_fsm i_fsm (
        .clk           (clk),
        .dma_rstn_sync (dma_rstn_sync),
        .capture_en_i  (capture_en_i),
        .burst_valid_i (burst_valid_i),
        .need_split_i  (need_split),
        .last_beat_i   (last_beat),
        .m_awready_i   (m_awready_i),
        .m_wready_i    (m_wready_i),
        .fifo_valid_i  (fifo_valid_i),
        .m_bvalid_i    (m_bvalid_i),
        .burst_ready_o (burst_ready_o),
        .load_start_o  (load_start),
        .accept_o      (accept),
        .split_next_o  (split_next),
        .advance_o     (advance),
        .aw_fire_o     (aw_fire),
        .w_fire_o      (w_fire),
        .in_data_o     (in_data),
        .m_awvalid_o   (m_awvalid_o),
        .m_wvalid_o    (m_wvalid_o),
        .fifo_ready_o  (fifo_ready_o),
        .m_bready_o    (m_bready_o)
    );

    wr_beat_counter i_cnt (
        .clk           (clk),
        .dma_rstn_sync (dma_rstn_sync),
        .aw_fire_i     (aw_fire),
        .w_fire_i      (w_fire),
        .in_data_i     (in_data),
        .awlen_i       (m_awlen_o),
        .last_beat_o   (last_beat),
        .m_wlast_o     (m_wlast_o)
    );

    wr_addr_ring i_ring (
        .clk           (clk),
        .dma_rstn_sync (dma_rstn_sync),
        .start_addr_i  (start_addr_i),
        .end_addr_i    (end_addr_i),
        .addr_reset_i  (addr_reset_i),
        .burst_len_i   (burst_len_i),
        .load_start_i  (load_start),
        .accept_i      (accept),
        .split_next_i  (split_next),
        .advance_i     (advance),
        .need_split_o  (need_split),
        .m_awaddr_o    (m_awaddr_o),
        .m_awlen_o     (m_awlen_o)
    );

    assign m_wdata_o = fifo_data_i;  // fifo word goes straight out

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
dma_pkg.sv
wr_burst_fsm.sv
wr_beat_counter.sv
wr_addr_ring.sv
fifo_axi_wr_dma.sv
dma_checker.sv
tb_fifo_axi_wr_dma.sv

// File: tb_fifo_axi_wr_dma.sv
`timescale 1ns/1ns
`include "dma_cfg.svh"
`default_nettype none

module tb_fifo_axi_wr_dma;
    import dma_pkg::*;

    localparam int    NUM_ROWS   = 16;
    localparam int    RING_START = 100;
    localparam int    RING_END   = 131;
    localparam int    DRIVE_DLY  = 2;
    localparam data_t WORD_BASE  = 32'hd000_0000;

    logic  clk, dma_rstn_sync;
    logic  capture_en_i, addr_reset_i, burst_valid_i, burst_ready_o;
    logic  fifo_valid_i, fifo_ready_o;
    logic  m_awvalid_o, m_awready_i, m_wlast_o, m_wvalid_o, m_wready_i;
    logic  m_bvalid_i, m_bready_o;
    addr_t start_addr_i, end_addr_i, m_awaddr_o;
    len_t  burst_len_i, m_awlen_o;
    data_t fifo_data_i, m_wdata_o;

    logic [16:0] lfsr_q = 17'd83104;
    addr_t exp_addr_q[$];
    len_t  exp_len_q[$];
    int    bursts_done = 0;
    int    w_beats     = 0;
    int    fifo_pops   = 0;
    int    beat_idx    = 0;
    int    cur_len     = 0;
    logic  in_burst    = 1'b0;
    logic  b_pending   = 1'b0;  // last beat sent, response owed
    logic  aw_owed     = 1'b0;  // request taken or second half due

    // req len, addr reset, capture drop, bursts, addr0, len0, addr1, len1
    int rows [NUM_ROWS][8] = '{
        '{ 7, 0, 0, 1, 100,  7,   0,  0},
        '{ 3, 0, 0, 1, 108,  3,   0,  0},
        '{15, 0, 0, 1, 112, 15,   0,  0},
        '{ 7, 0, 0, 2, 128,  3, 100,  3},  // crosses the end
        '{ 0, 0, 0, 1, 104,  0,   0,  0},
        '{ 4, 1, 0, 1, 100,  4,   0,  0},
        '{26, 0, 0, 1, 105, 26,   0,  0},  // ends exactly on 131
        '{ 1, 0, 0, 1, 100,  1,   0,  0},
        '{ 5, 0, 1, 1, 100,  5,   0,  0},
        '{31, 0, 0, 2, 106, 25, 100,  5},
        '{40, 0, 0, 2, 106, 25, 100, 14},
        '{31, 1, 0, 1, 100, 31,   0,  0},
        '{ 2, 0, 1, 1, 100,  2,   0,  0},
        '{28, 0, 0, 1, 103, 28,   0,  0},
        '{30, 0, 0, 1, 100, 30,   0,  0},
        '{ 2, 0, 0, 2, 131,  0, 100,  1}   // single beat first half
    };

    fifo_axi_wr_dma i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(`DMA_CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};  // x^17 + x^14 + 1
    endfunction

    task automatic draw_ready(output logic rdy);
        logic b0;
        logic b1;
        lfsr_q = lfsr_next(lfsr_q);
        b0     = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        b1     = lfsr_q[0];
        rdy    = b0 | b1;  // about one stall in four
    endtask

    task automatic stop_on_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_outputs_low(input string when_txt);
        assert (!burst_ready_o && !fifo_ready_o && !m_awvalid_o && !m_wvalid_o &&
                !m_wlast_o && !m_bready_o)
            else stop_on_error({"control output high ", when_txt});
    endtask

    task automatic wait_burst_ready();
        do @(negedge clk); while (!burst_ready_o);
    endtask

    task automatic run_row(input int r);
        int target;
        wait_burst_ready();
        if (rows[r][2] != 0) begin
            @(posedge clk);
            #DRIVE_DLY capture_en_i = 1'b0;
            repeat (3) @(posedge clk);
            #DRIVE_DLY capture_en_i = 1'b1;
            wait_burst_ready();
        end
        if (rows[r][1] != 0) begin
            @(posedge clk);
            #DRIVE_DLY addr_reset_i = 1'b1;
            @(posedge clk);
            #DRIVE_DLY addr_reset_i = 1'b0;
        end
        for (int k = 0; k < rows[r][3]; k++) begin
            exp_addr_q.push_back(addr_t'(rows[r][4 + 2 * k]));
            exp_len_q.push_back(len_t'(rows[r][5 + 2 * k]));
        end
        target = bursts_done + rows[r][3];
        @(posedge clk);
        #DRIVE_DLY burst_valid_i = 1'b1;
        burst_len_i = len_t'(rows[r][0]);
        wait_burst_ready();  // taken at the next edge
        @(posedge clk);
        #DRIVE_DLY burst_valid_i = 1'b0;
        while (bursts_done < target) @(negedge clk);
    endtask

    // slave and fifo side
    initial begin
        logic b_rdy;
        m_awready_i  = 1'b0;
        m_wready_i   = 1'b0;
        m_bvalid_i   = 1'b0;
        fifo_valid_i = 1'b0;
        fifo_data_i  = WORD_BASE;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            draw_ready(m_awready_i);
            draw_ready(m_wready_i);
            draw_ready(fifo_valid_i);
            draw_ready(b_rdy);
            m_bvalid_i  = b_pending && b_rdy;
            fifo_data_i = WORD_BASE + data_t'(fifo_pops);  // running counter
        end
    end

    always @(negedge clk) begin
        if (dma_rstn_sync) begin
            assert (i_dut.i_checker.fail_cnt == 0)
                else stop_on_error("protocol checker reported a violation");
            assert ((fifo_valid_i && fifo_ready_o) == (m_wvalid_o && m_wready_i))
                else stop_on_error("FIFO pop and W beat out of step");
            assert (m_awvalid_o == aw_owed)
                else stop_on_error($sformatf("awvalid %0b, expected %0b", m_awvalid_o, aw_owed));
            assert (m_bready_o == b_pending)
                else stop_on_error($sformatf("bready %0b, expected %0b", m_bready_o, b_pending));
            if (burst_valid_i && burst_ready_o) aw_owed = 1'b1;
            if (m_awvalid_o && m_awready_i) begin
                assert (!in_burst && !b_pending && exp_addr_q.size() != 0)
                    else stop_on_error("AW handshake while no burst was expected");
                assert (m_awaddr_o == exp_addr_q[0] && m_awlen_o == exp_len_q[0])
                    else stop_on_error($sformatf("AW addr %0d len %0d, expected addr %0d len %0d",
                        m_awaddr_o, m_awlen_o, exp_addr_q[0], exp_len_q[0]));
                cur_len  = int'(exp_len_q.pop_front());
                void'(exp_addr_q.pop_front());
                beat_idx = 0;
                in_burst = 1'b1;
                aw_owed  = 1'b0;
            end
            if (m_wvalid_o && m_wready_i) begin
                assert (in_burst) else stop_on_error("W beat outside a burst");
                assert (m_wdata_o == WORD_BASE + data_t'(w_beats))
                    else stop_on_error($sformatf("wdata %h, expected %h",
                        m_wdata_o, WORD_BASE + data_t'(w_beats)));
                assert (m_wlast_o == (beat_idx == cur_len))
                    else stop_on_error($sformatf("wlast %0b on beat %0d of a len %0d burst",
                        m_wlast_o, beat_idx, cur_len));
                w_beats++;
                if (beat_idx == cur_len) begin
                    in_burst  = 1'b0;
                    b_pending = 1'b1;
                end
                beat_idx++;
            end
            if (fifo_valid_i && fifo_ready_o) fifo_pops++;
            if (m_bvalid_i && m_bready_o) begin
                b_pending = 1'b0;
                bursts_done++;
                if (exp_addr_q.size() != 0) aw_owed = 1'b1;  // second half of a split
            end
        end
    end

    initial begin
        #(NUM_ROWS * 256 * 8 * `DMA_CLK_PERIOD);
        $display("watchdog expired, the DMA stopped making progress");
        $display("Errors found");
        $fatal(1, "timeout");
    end

    initial begin
        dma_rstn_sync = 1'b0;
        start_addr_i  = addr_t'(RING_START);
        end_addr_i    = addr_t'(RING_END);
        capture_en_i  = 1'b0;
        addr_reset_i  = 1'b0;
        burst_valid_i = 1'b0;
        burst_len_i   = '0;
        repeat (9) @(posedge clk);
        @(negedge clk) check_outputs_low("during reset");
        @(posedge clk);
        #DRIVE_DLY dma_rstn_sync = 1'b1;
        @(negedge clk) check_outputs_low("after reset with capture off");
        @(posedge clk);
        #DRIVE_DLY capture_en_i = 1'b1;
        @(negedge clk);
        assert (!burst_ready_o) else stop_on_error("burst_ready_o rose too early");
        @(negedge clk);
        assert (burst_ready_o) else stop_on_error("burst_ready_o did not rise");
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        repeat (4) @(negedge clk);
        assert (burst_ready_o)
            else stop_on_error("DMA did not return to waiting for a request");
        if (i_dut.i_checker.fail_cnt == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "protocol checker reported violations");
        end
    end

endmodule

`default_nettype wire

// File: wr_addr_ring.sv
`timescale 1ns/1ns
`default_nettype none

module wr_addr_ring (
    input  logic           clk,
    input  logic           dma_rstn_sync,
    input  dma_pkg::addr_t start_addr_i,
    input  dma_pkg::addr_t end_addr_i,
    input  logic           addr_reset_i,
    input  dma_pkg::len_t  burst_len_i,
    input  logic           load_start_i,
    input  logic           accept_i,
    input  logic           split_next_i,
    input  logic           advance_i,
    output logic           need_split_o,
    output dma_pkg::addr_t m_awaddr_o,
    output dma_pkg::len_t  m_awlen_o
);
    import dma_pkg::*;

    addr_t addr_q;
    len_t  len_q;
    len_t  req_len_q;   // whole request, needed for the second half
    logic  rst_pend_q;  // sticky until the next burst is taken
    addr_t base_addr;
    addr_t next_addr;

    // where the next accepted burst begins
    assign base_addr = rst_pend_q ? start_addr_i : addr_q;
    assign next_addr = addr_q + addr_t'(len_q) + addr_t'(1);

    assign need_split_o = (base_addr + addr_t'(burst_len_i)) > end_addr_i;

    always_ff @(posedge clk or negedge dma_rstn_sync) begin
        if (!dma_rstn_sync) begin
            rst_pend_q <= 1'b0;
        end else if (addr_reset_i) begin
            rst_pend_q <= 1'b1;
        end else if (load_start_i || accept_i) begin
            rst_pend_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge dma_rstn_sync) begin
        if (!dma_rstn_sync) begin
            addr_q <= '0;
            len_q  <= '0;
        end else if (load_start_i) begin
            addr_q <= start_addr_i;
        end else if (accept_i) begin
            addr_q <= base_addr;
            // first half stops at the end address
            len_q  <= need_split_o ? len_t'(end_addr_i - base_addr) : burst_len_i;
        end else if (split_next_i) begin
            addr_q <= start_addr_i;
            len_q  <= req_len_q - (len_q + len_t'(1));
        end else if (advance_i) begin
            addr_q <= (next_addr > end_addr_i) ? start_addr_i : next_addr; // wrap
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            req_len_q <= burst_len_i;
        end
    end

    assign m_awaddr_o = addr_q;
    assign m_awlen_o  = len_q;

endmodule

`default_nettype wire

// File: wr_beat_counter.sv
`timescale 1ns/1ns
`default_nettype none

module wr_beat_counter (
    input  logic          clk,
    input  logic          dma_rstn_sync,
    input  logic          aw_fire_i,
    input  logic          w_fire_i,
    input  logic          in_data_i,
    input  dma_pkg::len_t awlen_i,
    output logic          last_beat_o,
    output logic          m_wlast_o
);
    import dma_pkg::*;

    len_t beats_left_q;  // beats after the current one

    always_ff @(posedge clk or negedge dma_rstn_sync) begin
        if (!dma_rstn_sync) begin
            beats_left_q <= '0;
        end else if (aw_fire_i) begin
            beats_left_q <= awlen_i;
        end else if (w_fire_i && !last_beat_o) begin
            beats_left_q <= beats_left_q - len_t'(1);
        end
    end

    assign last_beat_o = in_data_i && (beats_left_q == '0);
    assign m_wlast_o   = last_beat_o;

endmodule

`default_nettype wire

// File: wr_burst_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module wr_burst_fsm (
    input  logic clk,
    input  logic dma_rstn_sync,
    input  logic capture_en_i,
    input  logic burst_valid_i,
    input  logic need_split_i,
    input  logic last_beat_i,
    input  logic m_awready_i,
    input  logic m_wready_i,
    input  logic fifo_valid_i,
    input  logic m_bvalid_i,
    output logic burst_ready_o,
    output logic load_start_o,
    output logic accept_o,
    output logic split_next_o,
    output logic advance_o,
    output logic aw_fire_o,
    output logic w_fire_o,
    output logic in_data_o,
    output logic m_awvalid_o,
    output logic m_wvalid_o,
    output logic fifo_ready_o,
    output logic m_bready_o
);
    import dma_pkg::*;

    burst_state_t state_q;
    burst_state_t state_d;
    logic         data_st;
    logic         b_fire;

    always_ff @(posedge clk or negedge dma_rstn_sync) begin
        if (!dma_rstn_sync) begin
            state_q <= ST_FIRST_LOAD;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_FIRST_LOAD: state_d = capture_en_i ? ST_LOAD_BURST : ST_FIRST_LOAD;
            ST_IDLE:       state_d = capture_en_i ? ST_LOAD_BURST : ST_FIRST_LOAD;
            ST_LOAD_BURST: begin
                if (!capture_en_i) begin
                    state_d = ST_FIRST_LOAD;
                end else if (accept_o) begin
                    state_d = need_split_i ? ST_ADDR_SPLIT : ST_ADDR;
                end
            end
            ST_ADDR:       state_d = aw_fire_o ? ST_DATA : ST_ADDR;
            ST_DATA:       state_d = (w_fire_o && last_beat_i) ? ST_RESP : ST_DATA;
            ST_RESP:       state_d = b_fire ? ST_IDLE : ST_RESP;
            ST_ADDR_SPLIT: state_d = aw_fire_o ? ST_DATA_SPLIT : ST_ADDR_SPLIT;
            ST_DATA_SPLIT: state_d = (w_fire_o && last_beat_i) ? ST_RESP_SPLIT : ST_DATA_SPLIT;
            ST_RESP_SPLIT: state_d = b_fire ? ST_ADDR : ST_RESP_SPLIT; // second half follows
            default:       state_d = ST_FIRST_LOAD;
        endcase
    end

    assign data_st = (state_q == ST_DATA) || (state_q == ST_DATA_SPLIT);

    // request side
    assign burst_ready_o = (state_q == ST_LOAD_BURST) && capture_en_i;
    assign accept_o      = burst_valid_i && burst_ready_o;
    assign load_start_o  = (state_q == ST_FIRST_LOAD) && capture_en_i;

    assign m_awvalid_o = (state_q == ST_ADDR) || (state_q == ST_ADDR_SPLIT);
    assign aw_fire_o   = m_awvalid_o && m_awready_i;

    // data state with a fifo word on offer
    assign in_data_o    = data_st && fifo_valid_i;
    assign m_wvalid_o   = in_data_o;
    assign fifo_ready_o = data_st && m_wready_i;
    assign w_fire_o     = m_wvalid_o && m_wready_i;

    assign m_bready_o   = (state_q == ST_RESP) || (state_q == ST_RESP_SPLIT);
    assign b_fire       = m_bvalid_i && m_bready_o;
    assign advance_o    = (state_q == ST_RESP) && b_fire;
    assign split_next_o = (state_q == ST_RESP_SPLIT) && b_fire;

endmodule

`default_nettype wire
